// ==== dv/id_model.svh ====
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// expected decode of one instruction word and whether it is known
function automatic id_pkg::decoded_t expect_decode(input logic [31:0] inst, output logic known);
    id_pkg::decoded_t d;
    logic [31:0] si12;
    logic [31:0] ui12;
    si12 = {{20{inst[21]}}, inst[21:10]};
    ui12 = {20'b0, inst[21:10]};
    d = '0;
    d.alu_op = id_pkg::alu_add;
    d.mem_op = id_pkg::mem_none;
    d.br_kind = id_pkg::br_none;
    d.dest = inst[4:0];
    d.rkd_addr = inst[14:10];
    d.br_offs = {{14{inst[25]}}, inst[25:10], 2'b00};
    known = 1'b1;
    if (inst[31:20] == 12'h001) begin
        d.uses_rj = 1'b1;
        d.uses_rkd = 1'b1;
        d.gr_we = 1'b1;
        case (inst[19:15])
            5'h00: d.alu_op = id_pkg::alu_add;
            5'h02: d.alu_op = id_pkg::alu_sub;
            5'h04: d.alu_op = id_pkg::alu_slt;
            5'h05: d.alu_op = id_pkg::alu_sltu;
            5'h08: d.alu_op = id_pkg::alu_nor;
            5'h09: d.alu_op = id_pkg::alu_and;
            5'h0a: d.alu_op = id_pkg::alu_or;
            5'h0b: d.alu_op = id_pkg::alu_xor;
            5'h0e: d.alu_op = id_pkg::alu_sll;
            5'h0f: d.alu_op = id_pkg::alu_srl;
            5'h10: d.alu_op = id_pkg::alu_sra;
            default: known = 1'b0;
        endcase
    end else if (inst[31:20] == 12'h004) begin
        d.uses_rj = 1'b1;
        d.src2_is_imm = 1'b1;
        d.gr_we = 1'b1;
        d.imm = {27'b0, inst[14:10]};
        case (inst[19:15])
            5'h01: d.alu_op = id_pkg::alu_sll;
            5'h09: d.alu_op = id_pkg::alu_srl;
            5'h11: d.alu_op = id_pkg::alu_sra;
            default: known = 1'b0;
        endcase
    end else if (inst[31:26] == 6'h00 || inst[31:26] == 6'h0a) begin
        d.uses_rj = 1'b1;
        d.src2_is_imm = 1'b1;
        d.gr_we = 1'b1;
        d.imm = si12;
        case (inst[31:22])
            10'h008: d.alu_op = id_pkg::alu_slt;
            10'h009: d.alu_op = id_pkg::alu_sltu;
            10'h00a: d.alu_op = id_pkg::alu_add;
            10'h00d: begin
                d.alu_op = id_pkg::alu_and;
                d.imm = ui12;
            end
            10'h00e: begin
                d.alu_op = id_pkg::alu_or;
                d.imm = ui12;
            end
            10'h00f: begin
                d.alu_op = id_pkg::alu_xor;
                d.imm = ui12;
            end
            10'h0a2: d.mem_op = id_pkg::mem_load;
            10'h0a6: begin
                d.mem_op = id_pkg::mem_store;
                d.gr_we = 1'b0;
                d.uses_rkd = 1'b1;
                d.rkd_addr = inst[4:0];
            end
            default: known = 1'b0;
        endcase
    end else if (inst[31:25] == 7'h0a || inst[31:25] == 7'h0e) begin
        d.src2_is_imm = 1'b1;
        d.gr_we = 1'b1;
        d.imm = {inst[24:5], 12'b0};
        if (inst[31:25] == 7'h0a) begin
            d.alu_op = id_pkg::alu_lui;
        end else begin
            d.src1_is_pc = 1'b1;
        end
    end else if (inst[31:26] >= 6'h13 && inst[31:26] <= 6'h1b) begin
        case (inst[31:26])
            6'h13: begin
                d.br_kind = id_pkg::br_jirl;
                d.uses_rj = 1'b1;
            end
            6'h14: d.br_kind = id_pkg::br_b;
            6'h15: begin
                d.br_kind = id_pkg::br_bl;
                d.dest = id_pkg::RA_REG;
            end
            6'h16: d.br_kind = id_pkg::br_beq;
            6'h17: d.br_kind = id_pkg::br_bne;
            6'h18: d.br_kind = id_pkg::br_blt;
            6'h19: d.br_kind = id_pkg::br_bge;
            6'h1a: d.br_kind = id_pkg::br_bltu;
            default: d.br_kind = id_pkg::br_bgeu;
        endcase
        if (inst[31:26] == 6'h14 || inst[31:26] == 6'h15) begin
            d.br_offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end
        // link forms write pc + 4
        if (inst[31:26] == 6'h13 || inst[31:26] == 6'h15) begin
            d.src1_is_pc = 1'b1;
            d.src2_is_imm = 1'b1;
            d.imm = 32'd4;
            d.gr_we = 1'b1;
        end
        if (inst[31:26] >= 6'h16) begin
            d.uses_rj = 1'b1;
            d.uses_rkd = 1'b1;
            d.rkd_addr = inst[4:0];
        end
    end else begin
        known = 1'b0;
    end
    if (!known) begin
        d.alu_op = id_pkg::alu_add;
        d.mem_op = id_pkg::mem_none;
        d.br_kind = id_pkg::br_none;
        d.gr_we = 1'b0;
        d.uses_rj = 1'b0;
        d.uses_rkd = 1'b0;
    end
    return d;
endfunction

// exe, then mem, then wb, then the register file
function automatic logic [31:0] forward_value(
    input logic [4:0]       addr,
    input id_pkg::fwd_src_t e,
    input id_pkg::fwd_src_t m,
    input id_pkg::fwd_src_t w,
    input logic [31:0]      reg_value
);
    if (addr == '0) begin
        return 32'd0;
    end
    if (e.dest == addr) begin
        return e.value;
    end
    if (m.dest == addr) begin
        return m.value;
    end
    if (w.dest == addr) begin
        return w.value;
    end
    return reg_value;
endfunction

function automatic logic expect_stall(
    input id_pkg::decoded_t d,
    input logic [4:0]       rj,
    input id_pkg::fwd_src_t e,
    input logic             is_load
);
    logic rj_hit;
    logic rkd_hit;
    rj_hit = d.uses_rj && rj != '0 && rj == e.dest;
    rkd_hit = d.uses_rkd && d.rkd_addr != '0 && d.rkd_addr == e.dest;
    return is_load && (rj_hit || rkd_hit);
endfunction

// condition and target as if the instruction leaves this cycle
function automatic id_pkg::branch_t expect_branch(
    input id_pkg::decoded_t d,
    input logic [31:0]      pc,
    input logic [31:0]      a,
    input logic [31:0]      b
);
    id_pkg::branch_t br;
    br.target = ((d.br_kind == id_pkg::br_jirl) ? a : pc) + d.br_offs;
    case (d.br_kind)
        id_pkg::br_b, id_pkg::br_bl, id_pkg::br_jirl: br.taken = 1'b1;
        id_pkg::br_beq: br.taken = a == b;
        id_pkg::br_bne: br.taken = a != b;
        id_pkg::br_blt: br.taken = $signed(a) < $signed(b);
        id_pkg::br_bge: br.taken = $signed(a) >= $signed(b);
        id_pkg::br_bltu: br.taken = a < b;
        id_pkg::br_bgeu: br.taken = a >= b;
        default: br.taken = 1'b0;
    endcase
    return br;
endfunction

`endif

// ==== dv/id_stage_tb.sv ====
`timescale 1ns/10ps

module id_stage_tb;

    localparam int NUM_CYCLES = 4000;
    localparam int DRAIN_LIMIT = 50;
    localparam logic [54:0] R3_FUNCS = {5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09,
                                        5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
    localparam logic [14:0] SHIFT_FUNCS = {5'h01, 5'h09, 5'h11};
    localparam logic [79:0] I12_OPS = {10'h008, 10'h009, 10'h00a, 10'h00d,
                                       10'h00e, 10'h00f, 10'h0a2, 10'h0a6};

    typedef logic [$bits(id_pkg::exe_pkt_t)-1:0] val_t;

    logic               clk;
    logic               reset;
    logic               in_valid;
    logic               in_ready;
    id_pkg::fetch_pkt_t in_data;
    logic               out_valid;
    logic               out_ready;
    id_pkg::exe_pkt_t   out_data;
    id_pkg::wb_write_t  wb_write;
    id_pkg::fwd_src_t   exe_fwd;
    id_pkg::fwd_src_t   mem_fwd;
    id_pkg::fwd_src_t   wb_fwd;
    logic               exe_is_load;
    id_pkg::branch_t    branch;

    id_pkg::fetch_pkt_t model_q[$];
    logic [31:0]        shadow [32];
    logic               checking;
    logic [31:0]        next_pc;
    logic               bp_prev = 1'b0;
    id_pkg::exe_pkt_t   prev_out = '0;
    int                 mismatch_count = 0;
    int                 timeout_count = 0;
    int                 transfers = 0;

    `include "id_model.svh"

    id_stage id_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_data     (in_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .wb_write    (wb_write),
        .exe_fwd     (exe_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .exe_is_load (exe_is_load),
        .branch      (branch)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input val_t got, input val_t expected);
        mismatch_count++;
        $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
    endtask

    // mostly a small register range so hazards come up often
    function automatic logic [4:0] pick_reg();
        if ($urandom_range(0, 3) == 0) begin
            return 5'($urandom_range(0, 31));
        end
        return 5'($urandom_range(0, 7));
    endfunction

    function automatic logic [4:0] pick_dest();
        id_pkg::fetch_pkt_t head;
        if (model_q.size() == 0 || $urandom_range(0, 2) == 0) begin
            return pick_reg();
        end
        head = model_q[0];
        case ($urandom_range(0, 2))
            0: return head.inst[9:5];
            1: return head.inst[14:10];
            default: return head.inst[4:0];
        endcase
    endfunction

    function automatic logic [31:0] random_inst();
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] r;
        int          idx;
        rd = pick_reg();
        rj = pick_reg();
        rk = pick_reg();
        r = $urandom();
        case ($urandom_range(0, 15))
            0, 1, 2, 3, 15: begin
                idx = $urandom_range(0, 10);
                return {12'h001, R3_FUNCS[5*idx +: 5], rk, rj, rd};
            end
            4: begin
                idx = $urandom_range(0, 2);
                return {12'h004, SHIFT_FUNCS[5*idx +: 5], r[4:0], rj, rd};
            end
            5, 6, 7: begin
                idx = $urandom_range(0, 7);
                return {I12_OPS[10*idx +: 10], r[11:0], rj, rd};
            end
            8: return {(r[0] ? 7'h0e : 7'h0a), r[31:12], rd};
            14: return r;
            default: begin
                idx = $urandom_range(0, 8);
                return {6'(19 + idx), r[15:0], rj, rd};
            end
        endcase
    endfunction

    task automatic drive_random();
        in_valid = $urandom_range(0, 3) != 0;
        in_data.pc = next_pc;
        in_data.inst = random_inst();
        next_pc = next_pc + 4;
        out_ready = $urandom_range(0, 3) != 0;
        // EXE holds its results while this stage is back-pressured
        if (bp_prev) begin
            wb_write.we = 1'b0;
        end else begin
            exe_is_load = $urandom_range(0, 2) == 0;
            exe_fwd.dest = pick_dest();
            exe_fwd.value = $urandom();
            mem_fwd.dest = pick_dest();
            mem_fwd.value = $urandom();
            wb_fwd.dest = pick_dest();
            wb_fwd.value = $urandom();
            wb_write.we = out_ready && $urandom_range(0, 1) == 1;
            wb_write.addr = pick_reg();
            wb_write.data = $urandom();
        end
    endtask

    task automatic check_transfer(
        input id_pkg::fetch_pkt_t head,
        input id_pkg::decoded_t   d,
        input logic               known,
        input logic [31:0]        a,
        input logic [31:0]        b
    );
        id_pkg::branch_t br;
        logic [31:0]     exp_src1;
        logic [31:0]     exp_src2;
        br = expect_branch(d, head.pc, a, b);
        exp_src1 = d.src1_is_pc ? head.pc : a;
        exp_src2 = d.src2_is_imm ? d.imm : b;
        assert (out_data.pc == head.pc)
            else report_mismatch("out_data.pc", val_t'(out_data.pc), val_t'(head.pc));
        assert (out_data.alu_op == d.alu_op)
            else report_mismatch("out_data.alu_op", val_t'(out_data.alu_op), val_t'(d.alu_op));
        assert (out_data.mem_op == d.mem_op)
            else report_mismatch("out_data.mem_op", val_t'(out_data.mem_op), val_t'(d.mem_op));
        assert (out_data.gr_we == d.gr_we)
            else report_mismatch("out_data.gr_we", val_t'(out_data.gr_we), val_t'(d.gr_we));
        if (known) begin
            assert (out_data.dest == d.dest)
                else report_mismatch("out_data.dest", val_t'(out_data.dest), val_t'(d.dest));
            assert (out_data.src1 == exp_src1)
                else report_mismatch("out_data.src1", val_t'(out_data.src1), val_t'(exp_src1));
            assert (out_data.src2 == exp_src2)
                else report_mismatch("out_data.src2", val_t'(out_data.src2), val_t'(exp_src2));
            assert (out_data.store_data == b)
                else report_mismatch("out_data.store_data", val_t'(out_data.store_data),
                                     val_t'(b));
            if (d.br_kind != id_pkg::br_none) begin
                assert (branch.target == br.target)
                    else report_mismatch("branch.target", val_t'(branch.target),
                                         val_t'(br.target));
            end
        end
        assert (branch.taken == br.taken)
            else report_mismatch("branch.taken", val_t'(branch.taken), val_t'(br.taken));
    endtask

    // sampled mid-cycle while the inputs are stable
    task automatic check_cycle();
        id_pkg::fetch_pkt_t head;
        id_pkg::decoded_t   d;
        logic               known;
        logic               has_head;
        logic               exp_valid;
        logic               exp_ready;
        logic [31:0]        a;
        logic [31:0]        b;
        has_head = model_q.size() != 0;
        head = '0;
        d = '0;
        known = 1'b0;
        a = '0;
        b = '0;
        exp_valid = 1'b0;
        if (has_head) begin
            head = model_q[0];
            d = expect_decode(head.inst, known);
            a = forward_value(head.inst[9:5], exe_fwd, mem_fwd, wb_fwd, shadow[head.inst[9:5]]);
            b = forward_value(d.rkd_addr, exe_fwd, mem_fwd, wb_fwd, shadow[d.rkd_addr]);
            exp_valid = !expect_stall(d, head.inst[9:5], exe_fwd, exe_is_load);
        end
        exp_ready = !has_head || (exp_valid && out_ready);
        assert (out_valid == exp_valid)
            else report_mismatch("out_valid", val_t'(out_valid), val_t'(exp_valid));
        assert (in_ready == exp_ready)
            else report_mismatch("in_ready", val_t'(in_ready), val_t'(exp_ready));
        if (bp_prev) begin
            assert (out_data == prev_out)
                else report_mismatch("out_data", val_t'(out_data), val_t'(prev_out));
        end
        if (exp_valid && out_ready) begin
            check_transfer(head, d, known, a, b);
            void'(model_q.pop_front());
            transfers++;
        end else begin
            assert (!branch.taken)
                else report_mismatch("branch.taken", val_t'(branch.taken), val_t'(1'b0));
        end
        if (in_valid && exp_ready) begin
            model_q.push_back(in_data);
        end
        if (wb_write.we && wb_write.addr != '0) begin
            shadow[wb_write.addr] = wb_write.data;
        end
        bp_prev = exp_valid && !out_ready;
        prev_out = out_data;
    endtask

    always @(negedge clk) begin
        if (checking) begin
            check_cycle();
        end
    end

    initial begin
        int wait_cycles;
        void'($urandom(53));
        reset = 1'b1;
        checking = 1'b0;
        next_pc = 32'h1c00_0000;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b0;
        wb_write = '0;
        exe_fwd = '0;
        mem_fwd = '0;
        wb_fwd = '0;
        exe_is_load = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        checking = 1'b1;

        // known contents for every register
        for (int i = 1; i < 32; i++) begin
            wb_write.we = 1'b1;
            wb_write.addr = 5'(i);
            wb_write.data = $urandom();
            @(posedge clk);
            #2;
        end
        wb_write.we = 1'b0;

        repeat (NUM_CYCLES) begin
            drive_random();
            @(posedge clk);
            #2;
        end

        in_valid = 1'b0;
        out_ready = 1'b1;
        exe_is_load = 1'b0;
        wb_write.we = 1'b0;
        wait_cycles = 0;
        while (model_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            #2;
            wait_cycles++;
        end
        if (model_q.size() != 0) begin
            timeout_count++;
            $display("timeout: %0d instructions never left the stage", model_q.size());
        end
        @(posedge clk);
        #2;

        $display("%0d transfers, %0d mismatches, %0d timeouts",
                 transfers, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== hdl/branch_unit.sv ====
`timescale 1ns/10ps

module branch_unit (
    input  id_pkg::decoded_t          dec,
    input  logic [id_pkg::DATA_W-1:0] pc,
    input  logic [id_pkg::DATA_W-1:0] rj_value,
    input  logic [id_pkg::DATA_W-1:0] rkd_value,
    input  logic                      fire,
    output id_pkg::branch_t           branch
);

    logic eq;
    logic ge_s;
    logic ge_u;
    logic cond;
    logic [id_pkg::DATA_W-1:0] base;

    assign eq   = rj_value == rkd_value;
    assign ge_s = $signed(rj_value) >= $signed(rkd_value);
    assign ge_u = rj_value >= rkd_value;

    always_comb begin
        case (dec.br_kind)
            id_pkg::br_b,
            id_pkg::br_bl,
            id_pkg::br_jirl: cond = 1'b1;
            id_pkg::br_beq:  cond = eq;
            id_pkg::br_bne:  cond = ~eq;
            id_pkg::br_blt:  cond = ~ge_s;
            id_pkg::br_bge:  cond = ge_s;
            id_pkg::br_bltu: cond = ~ge_u;
            id_pkg::br_bgeu: cond = ge_u;
            default:         cond = 1'b0;
        endcase
    end

    // jirl is register-relative, everything else pc-relative
    assign base = (dec.br_kind == id_pkg::br_jirl) ? rj_value : pc;

    assign branch.target = base + dec.br_offs;
    assign branch.taken  = cond && fire;

endmodule

// ==== hdl/id_pkg.sv ====
package id_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    // link register written by bl
    localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd1;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_b,
        br_bl,
        br_jirl,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu
    } br_kind_e;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } wb_write_t;

    // result a later stage is about to write back
    typedef struct packed {
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     value;
    } fwd_src_t;

    typedef struct packed {
        alu_op_e               alu_op;
        mem_op_e               mem_op;
        br_kind_e              br_kind;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  uses_rj;
        logic                  uses_rkd;
        logic [REG_ADDR_W-1:0] rkd_addr;
        logic [REG_ADDR_W-1:0] dest;
        logic                  gr_we;
        logic [DATA_W-1:0]     imm;
        logic [DATA_W-1:0]     br_offs;
    } decoded_t;

    typedef struct packed {
        alu_op_e               alu_op;
        mem_op_e               mem_op;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     src1;
        logic [DATA_W-1:0]     src2;
        logic [DATA_W-1:0]     store_data;
        logic [DATA_W-1:0]     pc;
    } exe_pkt_t;

    typedef struct packed {
        logic              taken;
        logic [DATA_W-1:0] target;
    } branch_t;

endpackage

// ==== hdl/id_stage.sv ====
`timescale 1ns/10ps

module id_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  id_pkg::fetch_pkt_t in_data,
    output logic               out_valid,
    input  logic               out_ready,
    output id_pkg::exe_pkt_t   out_data,
    input  id_pkg::wb_write_t  wb_write,
    input  id_pkg::fwd_src_t   exe_fwd,
    input  id_pkg::fwd_src_t   mem_fwd,
    input  id_pkg::fwd_src_t   wb_fwd,
    input  logic               exe_is_load,
    output id_pkg::branch_t    branch
);

    logic                          held_valid;
    id_pkg::fetch_pkt_t            held;
    id_pkg::decoded_t              dec;
    logic [id_pkg::REG_ADDR_W-1:0] rj_addr;
    logic [id_pkg::DATA_W-1:0]     rj_raw;
    logic [id_pkg::DATA_W-1:0]     rkd_raw;
    logic [id_pkg::DATA_W-1:0]     rj_value;
    logic [id_pkg::DATA_W-1:0]     rkd_value;
    logic                          stall;
    logic                          fire;

    assign out_valid = held_valid && !stall;
    assign fire      = out_valid && out_ready;
    assign in_ready  = !held_valid || fire;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (in_ready) begin
            held_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held <= in_data;
        end
    end

    assign rj_addr = held.inst[9:5];

    inst_decoder inst_decoder_inst (
        .inst (held.inst),
        .dec  (dec)
    );

    regfile regfile_inst (
        .clk    (clk),
        .raddr1 (rj_addr),
        .rdata1 (rj_raw),
        .raddr2 (dec.rkd_addr),
        .rdata2 (rkd_raw),
        .wr     (wb_write)
    );

    operand_forward operand_forward_inst (
        .rj_addr     (rj_addr),
        .rkd_addr    (dec.rkd_addr),
        .uses_rj     (dec.uses_rj),
        .uses_rkd    (dec.uses_rkd),
        .rj_raw      (rj_raw),
        .rkd_raw     (rkd_raw),
        .exe_fwd     (exe_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .exe_is_load (exe_is_load),
        .rj_value    (rj_value),
        .rkd_value   (rkd_value),
        .stall       (stall)
    );

    branch_unit branch_unit_inst (
        .dec       (dec),
        .pc        (held.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .fire      (fire),
        .branch    (branch)
    );

    // link instructions compute pc + 4 in EXE
    assign out_data.alu_op     = dec.alu_op;
    assign out_data.mem_op     = dec.mem_op;
    assign out_data.gr_we      = dec.gr_we;
    assign out_data.dest       = dec.dest;
    assign out_data.src1       = dec.src1_is_pc ? held.pc : rj_value;
    assign out_data.src2       = dec.src2_is_imm ? dec.imm : rkd_value;
    assign out_data.store_data = rkd_value;
    assign out_data.pc         = held.pc;

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder (
    input  logic [id_pkg::DATA_W-1:0] inst,
    output id_pkg::decoded_t          dec
);

    localparam logic [id_pkg::DATA_W-1:0] LINK_IMM = 4;

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic [id_pkg::DATA_W-1:0] imm_ui5;
    logic [id_pkg::DATA_W-1:0] imm_si12;
    logic [id_pkg::DATA_W-1:0] imm_ui12;
    logic [id_pkg::DATA_W-1:0] imm_si20;
    logic [id_pkg::DATA_W-1:0] offs16;
    logic [id_pkg::DATA_W-1:0] offs26;
    id_pkg::decoded_t d;
    logic legal;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i16      = inst[25:10];
    assign i20      = inst[24:5];
    assign i26      = {inst[9:0], inst[25:10]};

    assign imm_ui5  = {{(id_pkg::DATA_W-5){1'b0}}, rk};
    assign imm_si12 = {{(id_pkg::DATA_W-12){i12[11]}}, i12};
    assign imm_ui12 = {{(id_pkg::DATA_W-12){1'b0}}, i12};
    assign imm_si20 = {i20, 12'b0};
    assign offs16   = {{(id_pkg::DATA_W-18){i16[15]}}, i16, 2'b0};
    assign offs26   = {{(id_pkg::DATA_W-28){i26[25]}}, i26, 2'b0};

    always_comb begin
        d          = '0;
        d.alu_op   = id_pkg::alu_add;
        d.mem_op   = id_pkg::mem_none;
        d.br_kind  = id_pkg::br_none;
        d.rkd_addr = rk;
        d.dest     = rd;
        d.imm      = imm_si12;
        d.br_offs  = offs16;
        legal      = 1'b1;
        case (op_31_26)
            6'h00: begin
                d.uses_rj = 1'b1;
                d.gr_we   = 1'b1;
                if (op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
                    d.uses_rkd = 1'b1;
                    case (op_19_15)
                        5'h00:   d.alu_op = id_pkg::alu_add;
                        5'h02:   d.alu_op = id_pkg::alu_sub;
                        5'h04:   d.alu_op = id_pkg::alu_slt;
                        5'h05:   d.alu_op = id_pkg::alu_sltu;
                        5'h08:   d.alu_op = id_pkg::alu_nor;
                        5'h09:   d.alu_op = id_pkg::alu_and;
                        5'h0a:   d.alu_op = id_pkg::alu_or;
                        5'h0b:   d.alu_op = id_pkg::alu_xor;
                        5'h0e:   d.alu_op = id_pkg::alu_sll;
                        5'h0f:   d.alu_op = id_pkg::alu_srl;
                        5'h10:   d.alu_op = id_pkg::alu_sra;
                        default: legal = 1'b0;
                    endcase
                end else if (op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
                    // shift by ui5
                    d.src2_is_imm = 1'b1;
                    d.imm         = imm_ui5;
                    case (op_19_15)
                        5'h01:   d.alu_op = id_pkg::alu_sll;
                        5'h09:   d.alu_op = id_pkg::alu_srl;
                        5'h11:   d.alu_op = id_pkg::alu_sra;
                        default: legal = 1'b0;
                    endcase
                end else begin
                    d.src2_is_imm = 1'b1;
                    case (op_25_22)
                        4'h8: d.alu_op = id_pkg::alu_slt;
                        4'h9: d.alu_op = id_pkg::alu_sltu;
                        4'ha: d.alu_op = id_pkg::alu_add;
                        4'hd: begin
                            d.alu_op = id_pkg::alu_and;
                            d.imm    = imm_ui12;
                        end
                        4'he: begin
                            d.alu_op = id_pkg::alu_or;
                            d.imm    = imm_ui12;
                        end
                        4'hf: begin
                            d.alu_op = id_pkg::alu_xor;
                            d.imm    = imm_ui12;
                        end
                        default: legal = 1'b0;
                    endcase
                end
            end
            6'h05, 6'h07: begin
                // lu12i.w and pcaddu12i need bit 25 clear
                legal         = ~inst[25];
                d.src2_is_imm = 1'b1;
                d.gr_we       = 1'b1;
                d.imm         = imm_si20;
                if (op_31_26 == 6'h05) begin
                    d.alu_op = id_pkg::alu_lui;
                end else begin
                    d.src1_is_pc = 1'b1;
                end
            end
            6'h0a: begin
                d.uses_rj     = 1'b1;
                d.src2_is_imm = 1'b1;
                case (op_25_22)
                    4'h2: begin
                        d.mem_op = id_pkg::mem_load;
                        d.gr_we  = 1'b1;
                    end
                    4'h6: begin
                        d.mem_op   = id_pkg::mem_store;
                        d.uses_rkd = 1'b1;
                        d.rkd_addr = rd;
                    end
                    default: legal = 1'b0;
                endcase
            end
            6'h13: begin
                d.br_kind     = id_pkg::br_jirl;
                d.uses_rj     = 1'b1;
                d.src1_is_pc  = 1'b1;
                d.src2_is_imm = 1'b1;
                d.imm         = LINK_IMM;
                d.gr_we       = 1'b1;
            end
            6'h14: begin
                d.br_kind = id_pkg::br_b;
                d.br_offs = offs26;
            end
            6'h15: begin
                d.br_kind     = id_pkg::br_bl;
                d.br_offs     = offs26;
                d.src1_is_pc  = 1'b1;
                d.src2_is_imm = 1'b1;
                d.imm         = LINK_IMM;
                d.gr_we       = 1'b1;
                d.dest        = id_pkg::RA_REG;
            end
            6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: begin
                // compare rj against rd
                d.uses_rj  = 1'b1;
                d.uses_rkd = 1'b1;
                d.rkd_addr = rd;
                case (op_31_26)
                    6'h16:   d.br_kind = id_pkg::br_beq;
                    6'h17:   d.br_kind = id_pkg::br_bne;
                    6'h18:   d.br_kind = id_pkg::br_blt;
                    6'h19:   d.br_kind = id_pkg::br_bge;
                    6'h1a:   d.br_kind = id_pkg::br_bltu;
                    6'h1b:   d.br_kind = id_pkg::br_bgeu;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    // unknown encodings become a no-op without register write
    always_comb begin
        dec = d;
        if (!legal) begin
            dec.alu_op      = id_pkg::alu_add;
            dec.mem_op      = id_pkg::mem_none;
            dec.br_kind     = id_pkg::br_none;
            dec.src1_is_pc  = 1'b0;
            dec.src2_is_imm = 1'b0;
            dec.uses_rj     = 1'b0;
            dec.uses_rkd    = 1'b0;
            dec.gr_we       = 1'b0;
        end
    end

endmodule

// ==== hdl/operand_forward.sv ====
`timescale 1ns/10ps

module operand_forward (
    input  logic [id_pkg::REG_ADDR_W-1:0] rj_addr,
    input  logic [id_pkg::REG_ADDR_W-1:0] rkd_addr,
    input  logic                          uses_rj,
    input  logic                          uses_rkd,
    input  logic [id_pkg::DATA_W-1:0]     rj_raw,
    input  logic [id_pkg::DATA_W-1:0]     rkd_raw,
    input  id_pkg::fwd_src_t              exe_fwd,
    input  id_pkg::fwd_src_t              mem_fwd,
    input  id_pkg::fwd_src_t              wb_fwd,
    input  logic                          exe_is_load,
    output logic [id_pkg::DATA_W-1:0]     rj_value,
    output logic [id_pkg::DATA_W-1:0]     rkd_value,
    output logic                          stall
);

    // youngest producer wins
    function automatic logic [id_pkg::DATA_W-1:0] pick(
        input logic [id_pkg::REG_ADDR_W-1:0] addr,
        input logic [id_pkg::DATA_W-1:0]     raw,
        input id_pkg::fwd_src_t              e,
        input id_pkg::fwd_src_t              m,
        input id_pkg::fwd_src_t              w
    );
        logic [id_pkg::DATA_W-1:0] value;
        value = raw;
        if (w.dest != '0 && w.dest == addr) begin
            value = w.value;
        end
        if (m.dest != '0 && m.dest == addr) begin
            value = m.value;
        end
        if (e.dest != '0 && e.dest == addr) begin
            value = e.value;
        end
        return value;
    endfunction

    logic rj_hazard;
    logic rkd_hazard;

    assign rj_value  = pick(rj_addr, rj_raw, exe_fwd, mem_fwd, wb_fwd);
    assign rkd_value = pick(rkd_addr, rkd_raw, exe_fwd, mem_fwd, wb_fwd);

    // load result is not ready until MEM
    assign rj_hazard  = uses_rj && rj_addr != '0 && rj_addr == exe_fwd.dest;
    assign rkd_hazard = uses_rkd && rkd_addr != '0 && rkd_addr == exe_fwd.dest;
    assign stall      = exe_is_load && (rj_hazard || rkd_hazard);

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/10ps

module regfile (
    input  logic                          clk,
    input  logic [id_pkg::REG_ADDR_W-1:0] raddr1,
    output logic [id_pkg::DATA_W-1:0]     rdata1,
    input  logic [id_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [id_pkg::DATA_W-1:0]     rdata2,
    input  id_pkg::wb_write_t             wr
);

    localparam int NUM_REGS = 2 ** id_pkg::REG_ADDR_W;

    logic [id_pkg::DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 is hardwired to zero
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f verilog.f --top-module id_stage_tb -o id_stage_sim

sim_output=$(./obj_dir/id_stage_sim)
echo "$sim_output"
echo "$sim_output" | grep -q "Testbench passed"

// ==== verilog.f ====
+incdir+dv
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/id_stage.sv
dv/id_stage_tb.sv
